// File: rtl/rhPkg.sv
//////////////////////////////////////////////////////////////////////
// Controller-side definitions of the RH11 model
// Multi-bit fields are given by their low bit position
//////////////////////////////////////////////////////////////////////

`default_nettype none

package rhPkg;

   // Register word, word address and drive unit number
   typedef logic [15:0] word_t;
   typedef logic [1:0]  regAdr_t;
   typedef logic [2:0]  unit_t;

   // Register word addresses
   localparam regAdr_t ADR_CS1  = 2'd0;
   localparam regAdr_t ADR_CS2  = 2'd1;
   localparam regAdr_t ADR_DS   = 2'd2;
   localparam regAdr_t ADR_ER   = 2'd3;

   // CS1 bit positions
   localparam int CS1_SC   = 15;
   localparam int CS1_TRE  = 14;
   localparam int CS1_DVA  = 11;
   localparam int CS1_PSEL = 10;
   localparam int CS1_BAE  = 8;    // two bits, 9:8
   localparam int CS1_RDY  = 7;
   localparam int CS1_IE   = 6;
   localparam int CS1_FUN  = 1;    // five bits, 5:1
   localparam int CS1_GO   = 0;

   // CS2 bit positions
   localparam int CS2_NED  = 12;
   localparam int CS2_PGE  = 10;
   localparam int CS2_CLR  = 5;
   localparam int CS2_UNIT = 0;    // three bits, 2:0

endpackage

`default_nettype wire

// File: rtl/rpPkg.sv
//////////////////////////////////////////////////////////////////////
// Drive-side definitions of the RP drive model
// Only non-transfer functions have a code here
//////////////////////////////////////////////////////////////////////

`default_nettype none

package rpPkg;

   // Function codes as written to CS1 FUN
   typedef enum logic [4:0] {
      FUN_NOP     = 5'd0,
      FUN_UNLOAD  = 5'd1,
      FUN_SEEK    = 5'd2,
      FUN_RECAL   = 5'd3,
      FUN_DRVCLR  = 5'd4,
      FUN_RELEASE = 5'd5,
      FUN_SEARCH  = 5'd12
   } fun_t;

   // Drive FSM
   typedef enum logic {IDLE, BUSY} driveState_t;

   // DS and ER bit positions
   localparam int DS_ATA  = 15;
   localparam int DS_ERR  = 14;
   localparam int DS_DVA  = 7;
   localparam int DS_BUSY = 0;
   localparam int ER_ILF  = 0;

   // Cycles that a positioning function holds GO
   localparam int BUSY_CYCLES = 8;

endpackage

`default_nettype wire

// File: rtl/rhBusIf.sv
//////////////////////////////////////////////////////////////////////
// Wishbone classic slave for the RH11 registers, one wait state
// Master must hold its signals until ack. ER is read only
//////////////////////////////////////////////////////////////////////

`default_nettype none

module rhBusIf
(
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           cyc,
   input  wire logic           stb,
   input  wire logic           we,
   input  wire rhPkg::regAdr_t adr,
   input  wire logic [1:0]     sel,
   input  wire rhPkg::word_t   datWr,
   input  wire rhPkg::word_t   cs1,
   input  wire rhPkg::word_t   cs2,
   input  wire rhPkg::word_t   ds,
   input  wire rhPkg::word_t   er,
   output logic                ack,
   output rhPkg::word_t        datRd,
   output logic                cs1Wr,
   output logic                cs2Wr,
   output logic                dsWr,
   output logic                loByte,
   output logic                hiByte,
   output logic                drvAccess
);

   logic         setup;
   logic         wrSetup;
   rhPkg::word_t rdMux;

   // Setup cycle, request seen but not yet acknowledged
   assign setup   = cyc & stb & ~ack;
   assign wrSetup = setup & we;

   // Single-cycle ack, dropped at once if the master lets go
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= cyc & stb & ~ack;
   end

   // Write strobes land on the edge where ack rises
   assign cs1Wr  = wrSetup & (adr == rhPkg::ADR_CS1);
   assign cs2Wr  = wrSetup & (adr == rhPkg::ADR_CS2);
   assign dsWr   = wrSetup & (adr == rhPkg::ADR_DS);

   // Byte lanes
   assign loByte = sel[0];
   assign hiByte = sel[1];

   // Any drive register access, read or write
   assign drvAccess = setup & ((adr == rhPkg::ADR_DS) | (adr == rhPkg::ADR_ER));

   // Read data select
   always_comb
   begin
      case (adr)
         rhPkg::ADR_CS1: rdMux = cs1;
         rhPkg::ADR_CS2: rdMux = cs2;
         rhPkg::ADR_DS:  rdMux = ds;
         default:        rdMux = er;
      endcase
   end

   // Read data captured together with ack
   always_ff @(posedge clk)
   begin
      if (setup & ~we)
         datRd <= rdMux;
   end

endmodule

`default_nettype wire

// File: rtl/rhCs1.sv
//////////////////////////////////////////////////////////////////////
// RH11 CS1 register. CPE is not modelled and reads as zero
// FUN, GO and DVA come from the drive, the rest is held here
//////////////////////////////////////////////////////////////////////

`default_nettype none

module rhCs1
(
   input  wire logic         clk,
   input  wire logic         rst,
   input  wire logic         cs1Wr,
   input  wire logic         loByte,
   input  wire logic         hiByte,
   input  wire rhPkg::word_t datWr,
   input  wire logic         ctlClr,
   input  wire logic         goAccept,
   input  wire logic         ned,
   input  wire logic         pge,
   input  wire logic         ata,
   input  wire logic         err,
   input  wire logic         dva,
   input  wire logic         go,
   input  wire logic         iack,
   input  wire logic [4:0]   fun,
   output rhPkg::word_t      cs1,
   output logic              irq
);

   logic       statTre;
   logic       lastTre;
   logic       tre;
   logic       treClr;
   logic       rdy;
   logic       ie;
   logic       psel;
   logic [1:0] bae;
   logic       lastGo;
   logic       goDone;
   logic       ieSet;

   // Composite error, TRE set on its rising edge only
   assign statTre = ned | pge | err;
   assign treClr  = ctlClr | goAccept | (cs1Wr & hiByte & datWr[rhPkg::CS1_TRE]);
   assign rdy     = ~go;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         lastTre <= 1'b0;
         tre     <= 1'b0;
      end
      else
      begin
         lastTre <= statTre;
         if (treClr)
            tre <= 1'b0;
         else if (statTre & ~lastTre)
            tre <= 1'b1;
      end
   end

   // PSEL and bus address extension, high byte, only while ready
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         psel <= 1'b0;
         bae  <= 2'b00;
      end
      else if (ctlClr)
      begin
         psel <= 1'b0;
         bae  <= 2'b00;
      end
      else if (cs1Wr & hiByte & rdy)
      begin
         psel <= datWr[rhPkg::CS1_PSEL];
         bae  <= datWr[rhPkg::CS1_BAE +: 2];
      end
   end

   // Interrupt sources
   assign goDone = lastGo & ~go & ie;
   // Setting IE together with GO waits for completion instead
   assign ieSet  = cs1Wr & loByte & datWr[rhPkg::CS1_IE] & ~datWr[rhPkg::CS1_GO] & rdy;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ie     <= 1'b0;
         lastGo <= 1'b0;
         irq    <= 1'b0;
      end
      else
      begin
         lastGo <= go;
         // IE, low byte
         if (ctlClr | iack)
            ie <= 1'b0;
         else if (cs1Wr & loByte)
            ie <= datWr[rhPkg::CS1_IE];
         // Request held until acknowledged
         if (ctlClr | iack)
            irq <= 1'b0;
         else if (goDone | ieSet)
            irq <= 1'b1;
      end
   end

   // Register view
   always_comb
   begin
      cs1                           = '0;
      cs1[rhPkg::CS1_SC]            = tre | ata;
      cs1[rhPkg::CS1_TRE]           = tre;
      cs1[rhPkg::CS1_DVA]           = dva;
      cs1[rhPkg::CS1_PSEL]          = psel;
      cs1[rhPkg::CS1_BAE +: 2]      = bae;
      cs1[rhPkg::CS1_RDY]           = rdy;
      cs1[rhPkg::CS1_IE]            = ie;
      cs1[rhPkg::CS1_FUN +: 5]      = fun;
      cs1[rhPkg::CS1_GO]            = go;
   end

endmodule

`default_nettype wire

// File: rtl/rhCs2.sv
//////////////////////////////////////////////////////////////////////
// RH11 CS2 register. Only unit 0 exists, others give NED
// Low byte is the only writable lane
//////////////////////////////////////////////////////////////////////

`default_nettype none

module rhCs2
(
   input  wire logic         clk,
   input  wire logic         rst,
   input  wire logic         cs1Wr,
   input  wire logic         cs2Wr,
   input  wire logic         loByte,
   input  wire rhPkg::word_t datWr,
   input  wire logic         drvAccess,
   input  wire logic         go,
   output logic              funcWr,
   output logic              goAccept,
   output logic              ctlClr,
   output logic              ned,
   output logic              pge,
   output rhPkg::word_t      cs2
);

   rhPkg::unit_t unit;
   logic         goWr;
   logic         nedSet;
   logic         pgeSet;

   // CS1 write with GO set, and controller clear
   assign goWr   = cs1Wr & loByte & datWr[rhPkg::CS1_GO];
   assign ctlClr = cs2Wr & loByte & datWr[rhPkg::CS2_CLR];

   // GO dispatch
   always_comb
   begin
      nedSet = 1'b0;
      pgeSet = 1'b0;
      funcWr = 1'b0;
      if (goWr)
      begin
         if (unit != '0)
            nedSet = 1'b1;
         else if (go)
            pgeSet = 1'b1;
         else
            funcWr = 1'b1;
      end
      // Nothing answers on other units
      if (drvAccess && (unit != '0))
         nedSet = 1'b1;
   end

   // Accepted function also clears TRE in CS1
   assign goAccept = funcWr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         unit <= '0;
         ned  <= 1'b0;
         pge  <= 1'b0;
      end
      else if (ctlClr)
      begin
         unit <= '0;
         ned  <= 1'b0;
         pge  <= 1'b0;
      end
      else
      begin
         if (cs2Wr & loByte)
            unit <= datWr[rhPkg::CS2_UNIT +: 3];
         if (nedSet)
            ned <= 1'b1;
         if (pgeSet)
            pge <= 1'b1;
      end
   end

   // CLR always reads back as zero
   always_comb
   begin
      cs2                           = '0;
      cs2[rhPkg::CS2_NED]           = ned;
      cs2[rhPkg::CS2_PGE]           = pge;
      cs2[rhPkg::CS2_UNIT +: 3]     = unit;
   end

endmodule

`default_nettype wire

// File: rtl/rpDrive.sv
//////////////////////////////////////////////////////////////////////
// RP drive model, non-transfer functions only, unit 0
// funcWr is only issued while the drive is idle
//////////////////////////////////////////////////////////////////////

`default_nettype none

module rpDrive
(
   input  wire logic         clk,
   input  wire logic         rst,
   input  wire logic         funcWr,
   input  wire logic         ctlClr,
   input  wire logic         dsWr,
   input  wire rhPkg::word_t datWr,
   output logic              go,
   output logic              ata,
   output logic              err,
   output logic              dva,
   output logic [4:0]        fun,
   output rhPkg::word_t      ds,
   output rhPkg::word_t      er
);

   rpPkg::driveState_t                        state;
   logic [$clog2(rpPkg::BUSY_CYCLES)-1:0]     busyCnt;
   rpPkg::fun_t                               funCode;
   logic                                      ilf;
   logic                                      startBusy;
   logic                                      setIlf;
   logic                                      drvClr;
   logic                                      busyDone;

   assign funCode  = rpPkg::fun_t'(datWr[rhPkg::CS1_FUN +: 5]);
   assign busyDone = (state == rpPkg::BUSY) && (busyCnt == '0);

   // Function decode
   always_comb
   begin
      startBusy = 1'b0;
      setIlf    = 1'b0;
      drvClr    = ctlClr;
      if (funcWr)
      begin
         case (funCode)
            rpPkg::FUN_NOP, rpPkg::FUN_RELEASE:
               startBusy = 1'b0;
            rpPkg::FUN_DRVCLR:
               drvClr = 1'b1;
            // Recalibrate also brings the drive back online
            rpPkg::FUN_RECAL:
               startBusy = 1'b1;
            rpPkg::FUN_SEEK, rpPkg::FUN_SEARCH, rpPkg::FUN_UNLOAD:
            begin
               startBusy = dva;
               setIlf    = ~dva;
            end
            default:
               setIlf = 1'b1;
         endcase
      end
   end

   // Busy timer FSM
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= rpPkg::IDLE;
         busyCnt <= '0;
      end
      else
      begin
         case (state)
            rpPkg::IDLE:
               if (startBusy)
               begin
                  state   <= rpPkg::BUSY;
                  busyCnt <= $bits(busyCnt)'(rpPkg::BUSY_CYCLES - 1);
               end
            default:
               if (busyDone)
                  state <= rpPkg::IDLE;
               else
                  busyCnt <= busyCnt - 1'b1;
         endcase
      end
   end

   // Status bits
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fun <= '0;
         ilf <= 1'b0;
         ata <= 1'b0;
         dva <= 1'b1;
      end
      else
      begin
         if (funcWr)
            fun <= datWr[rhPkg::CS1_FUN +: 5];
         if (drvClr)
            ilf <= 1'b0;
         else if (setIlf)
            ilf <= 1'b1;
         // Attention on completion or error, cleared by writing 1
         if (drvClr | (dsWr & datWr[rpPkg::DS_ATA]))
            ata <= 1'b0;
         else if (setIlf | busyDone)
            ata <= 1'b1;
         if (startBusy && (funCode == rpPkg::FUN_UNLOAD))
            dva <= 1'b0;
         else if (startBusy && (funCode == rpPkg::FUN_RECAL))
            dva <= 1'b1;
      end
   end

   assign go  = (state == rpPkg::BUSY);
   assign err = ilf;

   always_comb
   begin
      ds                  = '0;
      ds[rpPkg::DS_ATA]   = ata;
      ds[rpPkg::DS_ERR]   = err;
      ds[rpPkg::DS_DVA]   = dva;
      ds[rpPkg::DS_BUSY]  = go;
      er                  = '0;
      er[rpPkg::ER_ILF]   = ilf;
   end

endmodule

`default_nettype wire

// File: rtl/rhTop.sv
//////////////////////////////////////////////////////////////////////
// RH11 controller with one RP drive on a Wishbone classic port
// Register word addresses 0 to 3 are CS1, CS2, DS and ER
//////////////////////////////////////////////////////////////////////

`default_nettype none

module rhTop
(
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           cyc,
   input  wire logic           stb,
   input  wire logic           we,
   input  wire rhPkg::regAdr_t adr,
   input  wire logic [1:0]     sel,
   input  wire rhPkg::word_t   datWr,
   output rhPkg::word_t        datRd,
   output logic                ack,
   input  wire logic           iack,
   output logic                irq
);

   // Bus interface strobes
   logic cs1Wr, cs2Wr, dsWr, loByte, hiByte, drvAccess;
   // Controller to drive
   logic funcWr, goAccept, ctlClr, ned, pge;
   // Drive status
   logic go, ata, err, dva;
   logic [4:0] fun;
   rhPkg::word_t cs1, cs2, ds, er;

   rhBusIf busIf_i (.clk, .rst, .cyc, .stb, .we, .adr, .sel, .datWr, .cs1, .cs2, .ds, .er,
                    .ack, .datRd, .cs1Wr, .cs2Wr, .dsWr, .loByte, .hiByte, .drvAccess);

   rhCs1 cs1_i (.clk, .rst, .cs1Wr, .loByte, .hiByte, .datWr, .ctlClr, .goAccept, .ned, .pge,
                .ata, .err, .dva, .go, .iack, .fun, .cs1, .irq);

   rhCs2 cs2_i (.clk, .rst, .cs1Wr, .cs2Wr, .loByte, .datWr, .drvAccess, .go, .funcWr,
                .goAccept, .ctlClr, .ned, .pge, .cs2);

   // Unit 0
   rpDrive drive_i (.clk, .rst, .funcWr, .ctlClr, .dsWr, .datWr, .go, .ata, .err, .dva,
                    .fun, .ds, .er);

endmodule

`default_nettype wire

// File: test/rhTb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the RH11 controller with one RP drive
// Busy windows are assumed to last at least a few bus cycles
//////////////////////////////////////////////////////////////////////

`default_nettype none

module rhTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ACK_LIMIT   = 20;
   localparam int READY_LIMIT = 64;
   localparam int IRQ_LIMIT   = 200;

   logic            clk;
   logic            rst;
   logic            cyc;
   logic            stb;
   logic            we;
   logic            iack;
   logic            ack;
   logic            irq;
   logic [1:0]      sel;
   rhPkg::regAdr_t  adr;
   rhPkg::word_t    datWr;
   rhPkg::word_t    datRd;
   rhPkg::word_t    rd;

   integer seed = 32'h4f0d_6975;
   int     checks;
   int     errors;
   int     testStart;

   rhTop dut_i (.clk, .rst, .cyc, .stb, .we, .adr, .sel, .datWr, .datRd, .ack, .iack, .irq);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Expected register images
   //////////////////////////////////////////////////////////////////////

   // RDY is always the inverse of GO
   function automatic rhPkg::word_t cs1Exp(input logic sc, tre, dva, psel,
                                           input logic [1:0] bae, input logic ie,
                                           input logic [4:0] fun, input logic go);
      rhPkg::word_t w;
      w                        = '0;
      w[rhPkg::CS1_SC]         = sc;
      w[rhPkg::CS1_TRE]        = tre;
      w[rhPkg::CS1_DVA]        = dva;
      w[rhPkg::CS1_PSEL]       = psel;
      w[rhPkg::CS1_BAE +: 2]   = bae;
      w[rhPkg::CS1_RDY]        = ~go;
      w[rhPkg::CS1_IE]         = ie;
      w[rhPkg::CS1_FUN +: 5]   = fun;
      w[rhPkg::CS1_GO]         = go;
      return w;
   endfunction

   function automatic rhPkg::word_t dsExp(input logic ata, err, dva, busy);
      rhPkg::word_t w;
      w                  = '0;
      w[rpPkg::DS_ATA]   = ata;
      w[rpPkg::DS_ERR]   = err;
      w[rpPkg::DS_DVA]   = dva;
      w[rpPkg::DS_BUSY]  = busy;
      return w;
   endfunction

   // CS1 low byte with GO
   function automatic rhPkg::word_t cmdWord(input logic [4:0] fun, input logic ie);
      rhPkg::word_t w;
      w                        = '0;
      w[rhPkg::CS1_FUN +: 5]   = fun;
      w[rhPkg::CS1_IE]         = ie;
      w[rhPkg::CS1_GO]         = 1'b1;
      return w;
   endfunction

   // SEEK with a random high byte, which the low lane must ignore
   function automatic rhPkg::word_t seekCmd(input logic ie);
      rhPkg::word_t rnd;
      rnd = $random(seed);
      return {rnd[15:8], 8'h00} | cmdWord(rpPkg::FUN_SEEK, ie);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Bus tasks and checks
   //////////////////////////////////////////////////////////////////////

   task automatic abortRun(input string what);
      $display("timeout at %0t ns: %s", $time, what);
      $display("Testbench failed");
      $finish;
   endtask

   task automatic writeReg(input rhPkg::regAdr_t a, input logic [1:0] s, input rhPkg::word_t d);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = 1'b1;
      adr   = a;
      sel   = s;
      datWr = d;
      @(posedge clk);
      #1;
      while (!ack && n < ACK_LIMIT)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!ack)
         abortRun("the DUT never acknowledged a register write");
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   // Data is captured on the ack edge, stable here
   task automatic readReg(input rhPkg::regAdr_t a, output rhPkg::word_t d);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      sel = 2'b11;
      @(posedge clk);
      #1;
      while (!ack && n < ACK_LIMIT)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!ack)
         abortRun("the DUT never acknowledged a register read");
      d   = datRd;
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   // Poll CS1 until the drive is ready again
   task automatic waitReady();
      rhPkg::word_t d;
      int           n;
      n = 0;
      readReg(rhPkg::ADR_CS1, d);
      while (!d[rhPkg::CS1_RDY] && n < READY_LIMIT)
      begin
         readReg(rhPkg::ADR_CS1, d);
         n++;
      end
      if (!d[rhPkg::CS1_RDY])
         abortRun("CS1 RDY never came back after a function");
   endtask

   task automatic waitIrq();
      int n;
      n = 0;
      while (!irq && n < IRQ_LIMIT)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!irq)
         abortRun("no interrupt request after the function completed");
   endtask

   task automatic pulseIack();
      @(posedge clk);
      #1;
      iack = 1'b1;
      @(posedge clk);
      #1;
      iack = 1'b0;
   endtask

   task automatic checkWord(input string what, input rhPkg::word_t got, input rhPkg::word_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkLevel(input string what, input logic got, input logic exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic closeTest(input string name);
      $display("%s: %s, %0d errors", name, (errors == testStart) ? "ok" : "mismatch",
               errors - testStart);
      testStart = errors;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      rst       = 1'b1;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      iack      = 1'b0;
      adr       = rhPkg::ADR_CS1;
      sel       = 2'b00;
      datWr     = '0;
      checks    = 0;
      errors    = 0;
      testStart = 0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      // Reset state and byte lanes
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after reset", rd, cs1Exp(0, 0, 1, 0, 2'b00, 0, rpPkg::FUN_NOP, 0));
      checkLevel("irq after reset", irq, 1'b0);
      // Bits on the other lane must be ignored
      datWr = '0;
      writeReg(rhPkg::ADR_CS1, 2'b01, 16'h0740);
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after low byte", rd, cs1Exp(0, 0, 1, 0, 2'b00, 1, rpPkg::FUN_NOP, 0));
      checkLevel("irq after IE write", irq, 1'b1);
      // IE clear in the low lane, so IE must survive
      writeReg(rhPkg::ADR_CS1, 2'b10, 16'h0700);
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after high byte", rd, cs1Exp(0, 0, 1, 1, 2'b11, 1, rpPkg::FUN_NOP, 0));
      writeReg(rhPkg::ADR_CS1, 2'b11, 16'h0000);
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 cleared", rd, cs1Exp(0, 0, 1, 0, 2'b00, 0, rpPkg::FUN_NOP, 0));
      pulseIack();
      checkLevel("irq after iack", irq, 1'b0);
      closeTest("test 1 reset and byte lanes");

      // SEEK and attention
      writeReg(rhPkg::ADR_CS1, 2'b01, seekCmd(0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 during SEEK", rd, cs1Exp(0, 0, 1, 0, 2'b00, 0, rpPkg::FUN_SEEK, 1));
      readReg(rhPkg::ADR_DS, rd);
      checkWord("DS during SEEK", rd, dsExp(0, 0, 1, 1));
      waitReady();
      readReg(rhPkg::ADR_DS, rd);
      checkWord("DS after SEEK", rd, dsExp(1, 0, 1, 0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after SEEK", rd, cs1Exp(1, 0, 1, 0, 2'b00, 0, rpPkg::FUN_SEEK, 0));
      writeReg(rhPkg::ADR_DS, 2'b11, 16'h1 << rpPkg::DS_ATA);
      readReg(rhPkg::ADR_DS, rd);
      checkWord("DS after ATA clear", rd, dsExp(0, 0, 1, 0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after ATA clear", rd, cs1Exp(0, 0, 1, 0, 2'b00, 0, rpPkg::FUN_SEEK, 0));
      closeTest("test 2 seek and attention");

      // Illegal function, then TRE and DRVCLR
      writeReg(rhPkg::ADR_CS1, 2'b01, cmdWord(5'd6, 0));
      readReg(rhPkg::ADR_ER, rd);
      checkWord("ER after illegal code", rd, 16'h1 << rpPkg::ER_ILF);
      readReg(rhPkg::ADR_DS, rd);
      checkWord("DS after illegal code", rd, dsExp(1, 1, 1, 0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after illegal code", rd, cs1Exp(1, 1, 1, 0, 2'b00, 0, 5'd6, 0));
      // TRE cleared first so DRVCLR cannot be the cause
      writeReg(rhPkg::ADR_CS1, 2'b10, 16'h1 << rhPkg::CS1_TRE);
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after TRE clear", rd, cs1Exp(1, 0, 1, 0, 2'b00, 0, 5'd6, 0));
      writeReg(rhPkg::ADR_CS1, 2'b01, cmdWord(rpPkg::FUN_DRVCLR, 0));
      readReg(rhPkg::ADR_ER, rd);
      checkWord("ER after DRVCLR", rd, 16'h0000);
      readReg(rhPkg::ADR_DS, rd);
      checkWord("DS after DRVCLR", rd, dsExp(0, 0, 1, 0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after DRVCLR", rd, cs1Exp(0, 0, 1, 0, 2'b00, 0, rpPkg::FUN_DRVCLR, 0));
      closeTest("test 3 illegal function");

      // GO while busy, wrong unit, controller clear
      writeReg(rhPkg::ADR_CS1, 2'b01, seekCmd(0));
      writeReg(rhPkg::ADR_CS1, 2'b01, cmdWord(rpPkg::FUN_RECAL, 0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after GO while busy", rd,
                cs1Exp(1, 1, 1, 0, 2'b00, 0, rpPkg::FUN_SEEK, 1));
      waitReady();
      readReg(rhPkg::ADR_CS2, rd);
      checkWord("CS2 after GO while busy", rd, 16'h1 << rhPkg::CS2_PGE);
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 function kept", rd, cs1Exp(1, 1, 1, 0, 2'b00, 0, rpPkg::FUN_SEEK, 0));
      writeReg(rhPkg::ADR_DS, 2'b11, 16'h1 << rpPkg::DS_ATA);
      writeReg(rhPkg::ADR_CS2, 2'b01, 16'h0001);
      readReg(rhPkg::ADR_DS, rd);
      readReg(rhPkg::ADR_CS2, rd);
      checkWord("CS2 after unit 1 access", rd,
                (16'h1 << rhPkg::CS2_NED) | (16'h1 << rhPkg::CS2_PGE) | 16'h0001);
      writeReg(rhPkg::ADR_CS2, 2'b01, 16'h1 << rhPkg::CS2_CLR);
      readReg(rhPkg::ADR_CS2, rd);
      checkWord("CS2 after CLR", rd, 16'h0000);
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after CLR", rd, cs1Exp(0, 0, 1, 0, 2'b00, 0, rpPkg::FUN_SEEK, 0));
      closeTest("test 4 program errors and clear");

      // Interrupt on completion, then drive availability
      writeReg(rhPkg::ADR_CS1, 2'b01, seekCmd(1));
      waitIrq();
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 at interrupt", rd, cs1Exp(1, 0, 1, 0, 2'b00, 1, rpPkg::FUN_SEEK, 0));
      pulseIack();
      checkLevel("irq after iack", irq, 1'b0);
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after iack", rd, cs1Exp(1, 0, 1, 0, 2'b00, 0, rpPkg::FUN_SEEK, 0));
      writeReg(rhPkg::ADR_DS, 2'b11, 16'h1 << rpPkg::DS_ATA);
      writeReg(rhPkg::ADR_CS1, 2'b01, cmdWord(rpPkg::FUN_UNLOAD, 0));
      waitReady();
      readReg(rhPkg::ADR_DS, rd);
      checkWord("DS after UNLOAD", rd, dsExp(1, 0, 0, 0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after UNLOAD", rd, cs1Exp(1, 0, 0, 0, 2'b00, 0, rpPkg::FUN_UNLOAD, 0));
      writeReg(rhPkg::ADR_DS, 2'b11, 16'h1 << rpPkg::DS_ATA);
      // Drive offline, SEEK is refused
      writeReg(rhPkg::ADR_CS1, 2'b01, seekCmd(0));
      readReg(rhPkg::ADR_ER, rd);
      checkWord("ER after offline SEEK", rd, 16'h1 << rpPkg::ER_ILF);
      readReg(rhPkg::ADR_DS, rd);
      checkWord("DS after offline SEEK", rd, dsExp(1, 1, 0, 0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after offline SEEK", rd,
                cs1Exp(1, 1, 0, 0, 2'b00, 0, rpPkg::FUN_SEEK, 0));
      writeReg(rhPkg::ADR_CS1, 2'b01, cmdWord(rpPkg::FUN_RECAL, 0));
      waitReady();
      readReg(rhPkg::ADR_DS, rd);
      checkWord("DS after RECAL", rd, dsExp(1, 1, 1, 0));
      readReg(rhPkg::ADR_CS1, rd);
      checkWord("CS1 after RECAL", rd, cs1Exp(1, 0, 1, 0, 2'b00, 0, rpPkg::FUN_RECAL, 0));
      closeTest("test 5 interrupt and drive available");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
rtl/rhPkg.sv
rtl/rpPkg.sv
rtl/rhBusIf.sv
rtl/rhCs1.sv
rtl/rhCs2.sv
rtl/rpDrive.sv
rtl/rhTop.sv
test/rhTb.sv

// File: Bender.yml
package:
  name: rh11_rp

sources:
  - rtl/rhPkg.sv
  - rtl/rpPkg.sv
  - rtl/rhBusIf.sv
  - rtl/rhCs1.sv
  - rtl/rhCs2.sv
  - rtl/rpDrive.sv
  - rtl/rhTop.sv

  - target: test
    files:
      - test/rhTb.sv
